//--- hdl/pc_pkg.sv
package pc_pkg;

   // branch conditions, encoded as the RISC-V funct3 field
   typedef enum logic [2:0] {
      cmp_beq  = 3'b000,
      cmp_bne  = 3'b001,
      cmp_blt  = 3'b100,
      cmp_bge  = 3'b101,
      cmp_bltu = 3'b110,
      cmp_bgeu = 3'b111
   } cmp_op_e;

   // flow-control bundle for one decoded instruction
   typedef struct packed {
      logic        valid;
      logic        branch;
      logic        jump;
      logic        jalr;
      logic        ebreak;
      logic        ecall;
      logic        mret;
      logic        rs1_hazard;  // rs1 not ready, wait for forwarding
      cmp_op_e     cmp_op;
      logic [63:0] imm;
   } ctrl_t;

   typedef enum logic {
      csr_mtvec = 1'b0,
      csr_mepc  = 1'b1
   } csr_sel_e;

   // software write port into the trap CSRs
   typedef struct packed {
      logic        we;
      csr_sel_e    sel;
      logic [63:0] data;
   } csr_wr_t;

   // event reported by the sequencer, one-cycle strobe
   typedef enum logic [1:0] {
      trap_none  = 2'd0,
      trap_ecall = 2'd1,
      trap_irq   = 2'd2,
      trap_mret  = 2'd3
   } trap_kind_e;

endpackage

//--- hdl/branch_cmp.sv
`timescale 1ns/10ps

module branch_cmp #(
   parameter int XLEN = 64
) (
   input  pc_pkg::cmp_op_e  cmp_op,
   input  logic [XLEN-1:0]  a,
   input  logic [XLEN-1:0]  b,
   output logic             taken
);

   import pc_pkg::*;

   logic eq;
   logic lt_s;
   logic lt_u;

   // one comparator of each kind, shared by the six conditions
   assign eq   = (a == b);
   assign lt_s = ($signed(a) < $signed(b));
   assign lt_u = (a < b);

   always_comb begin
      case (cmp_op)
         cmp_beq:  taken = eq;
         cmp_bne:  taken = !eq;
         cmp_blt:  taken = lt_s;
         cmp_bge:  taken = !lt_s;   // greater or equal, signed
         cmp_bltu: taken = lt_u;
         cmp_bgeu: taken = !lt_u;
         default:  taken = 1'b0;    // funct3 010/011 are not branches
      endcase
   end

endmodule

//--- hdl/pc_sequencer.sv
`timescale 1ns/10ps

module pc_sequencer #(
   parameter int          XLEN     = 64,
   parameter logic [63:0] RESET_PC = 64'h8000_0000
) (
   input  logic               clk,
   input  logic               rst_n,
   input  pc_pkg::ctrl_t      ctrl,
   input  logic               taken,
   input  logic [XLEN-1:0]    rs1_data,
   input  logic [XLEN-1:0]    fwd_data,
   input  logic [XLEN-1:0]    mtvec,
   input  logic [XLEN-1:0]    mepc,
   input  logic               irq_pending,
   output logic [XLEN-1:0]    pc,
   output logic               jalr_stall,
   output pc_pkg::trap_kind_e trap_kind,
   output logic [XLEN-1:0]    epc
);

   import pc_pkg::*;

   logic [XLEN-1:0] imm;
   logic [XLEN-1:0] pc_plus4;
   logic [XLEN-1:0] next_pc;
   logic [XLEN-1:0] imm_q;     // immediate of the stalled jalr
   logic            hold_q;    // jalr waiting for forwarded rs1
   logic            hold_d;

   assign imm      = ctrl.imm[XLEN-1:0];
   assign pc_plus4 = pc + XLEN'(4);

   // target selection, highest priority first
   always_comb begin
      next_pc    = pc;
      hold_d     = 1'b0;
      jalr_stall = 1'b0;
      trap_kind  = trap_none;
      epc        = pc;
      if (hold_q) begin
         // second cycle of a stalled jalr, ctrl is don't-care here
         next_pc = fwd_data + imm_q;
      end else if (ctrl.valid) begin
         if (ctrl.branch) begin
            next_pc = taken ? pc + imm : pc_plus4;
         end else if (ctrl.jump && !ctrl.jalr) begin
            next_pc = pc + imm;           // jal
         end else if (ctrl.jalr && !ctrl.rs1_hazard) begin
            next_pc = rs1_data + imm;
         end else if (ctrl.jalr) begin
            jalr_stall = 1'b1;            // pc holds this cycle
            hold_d     = 1'b1;
         end else if (ctrl.ebreak) begin
            next_pc = RESET_PC[XLEN-1:0];
         end else if (ctrl.ecall) begin
            next_pc   = mtvec;
            trap_kind = trap_ecall;
            epc       = pc;               // ecall itself is re-executed on return
         end else if (ctrl.mret) begin
            next_pc   = mepc;
            trap_kind = trap_mret;
         end else if (irq_pending) begin
            // current instruction retires, resume after it
            next_pc   = mtvec;
            trap_kind = trap_irq;
            epc       = pc_plus4;
         end else begin
            next_pc = pc_plus4;
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pc     <= RESET_PC[XLEN-1:0];
         hold_q <= 1'b0;
      end else begin
         pc     <= next_pc;
         hold_q <= hold_d;
      end
   end

   always_ff @(posedge clk) begin
      if (hold_d) begin
         imm_q <= imm;
      end
   end

   // every target source must keep the fetch address word aligned
   a_pc_aligned: assert property (
      @(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00
   ) else $error("pc not 4-byte aligned: %h", pc);

   // decode keeps valid low while the held jalr completes, its ctrl would be lost
   a_hold_no_issue: assert property (
      @(posedge clk) disable iff (!rst_n) hold_q |-> !ctrl.valid
   ) else $error("valid instruction presented during jalr hold");

endmodule

//--- hdl/trap_csr.sv
`timescale 1ns/10ps

module trap_csr #(
   parameter int XLEN = 64
) (
   input  logic               clk,
   input  logic               rst_n,
   input  pc_pkg::csr_wr_t    csr_wr,
   input  pc_pkg::trap_kind_e trap_kind,
   input  logic [XLEN-1:0]    epc,
   input  logic               timer_irq,
   output logic [XLEN-1:0]    mtvec,
   output logic [XLEN-1:0]    mepc,
   output logic               irq_pending,
   output logic               trap_taken
);

   import pc_pkg::*;

   logic            mie_q;
   logic            mpie_q;
   logic            trap_enter;
   logic            set_mie;     // mtvec write with bit 3 also enables interrupts
   logic [XLEN-1:0] wdata;

   assign irq_pending = timer_irq & mie_q;
   assign trap_enter  = (trap_kind == trap_ecall) || (trap_kind == trap_irq);

   always_comb begin
      wdata   = csr_wr.data[XLEN-1:0];
      set_mie = 1'b0;
      if (csr_wr.sel == csr_mtvec && wdata[3]) begin
         set_mie  = 1'b1;
         wdata[3] = 1'b0;   // bit 3 is a control flag, not part of the vector
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         mtvec      <= '0;
         mepc       <= '0;
         mie_q      <= 1'b0;
         mpie_q     <= 1'b0;
         trap_taken <= 1'b0;
      end else begin
         // software writes first, trap bookkeeping below overrides them
         if (csr_wr.we) begin
            if (csr_wr.sel == csr_mtvec) begin
               mtvec <= wdata;
               if (set_mie) begin
                  mie_q <= 1'b1;
               end
            end else begin
               mepc <= wdata;
            end
         end
         if (trap_enter) begin
            mepc   <= epc;
            mpie_q <= mie_q;
            mie_q  <= 1'b0;   // no nested interrupts
         end else if (trap_kind == trap_mret) begin
            mie_q  <= mpie_q;
            mpie_q <= 1'b1;
         end
         trap_taken <= trap_enter;
      end
   end

   // the sequencer may only report an interrupt that this unit let through
   a_irq_needs_mie: assert property (
      @(posedge clk) disable iff (!rst_n) !(trap_kind == trap_irq && !mie_q)
   ) else $error("interrupt taken with mie clear");

endmodule

//--- hdl/pc_unit_top.sv
`timescale 1ns/10ps

module pc_unit_top #(
   parameter int          XLEN     = 64,
   parameter logic [63:0] RESET_PC = 64'h8000_0000
) (
   input  logic            clk,
   input  logic            rst_n,
   input  pc_pkg::ctrl_t   ctrl,
   input  logic [XLEN-1:0] rs1_data,
   input  logic [XLEN-1:0] fwd_data,
   input  logic [XLEN-1:0] cmp_a,
   input  logic [XLEN-1:0] cmp_b,
   input  pc_pkg::csr_wr_t csr_wr,
   input  logic            timer_irq,
   output logic [XLEN-1:0] pc,
   output logic            jalr_stall,
   output logic            trap_taken
);

   import pc_pkg::*;

   logic            taken;
   logic [XLEN-1:0] mtvec;
   logic [XLEN-1:0] mepc;
   logic            irq_pending;   // timer_irq already gated by mie
   trap_kind_e      trap_kind;
   logic [XLEN-1:0] epc;

   branch_cmp #(
      .XLEN(XLEN)
   ) u_branch_cmp (
      .cmp_op (ctrl.cmp_op),
      .a      (cmp_a),
      .b      (cmp_b),
      .taken  (taken)
   );

   pc_sequencer #(
      .XLEN     (XLEN),
      .RESET_PC (RESET_PC)
   ) u_pc_sequencer (
      .clk         (clk),
      .rst_n       (rst_n),
      .ctrl        (ctrl),
      .taken       (taken),
      .rs1_data    (rs1_data),
      .fwd_data    (fwd_data),
      .mtvec       (mtvec),
      .mepc        (mepc),
      .irq_pending (irq_pending),
      .pc          (pc),
      .jalr_stall  (jalr_stall),
      .trap_kind   (trap_kind),
      .epc         (epc)
   );

   trap_csr #(
      .XLEN(XLEN)
   ) u_trap_csr (
      .clk         (clk),
      .rst_n       (rst_n),
      .csr_wr      (csr_wr),
      .trap_kind   (trap_kind),
      .epc         (epc),
      .timer_irq   (timer_irq),
      .mtvec       (mtvec),
      .mepc        (mepc),
      .irq_pending (irq_pending),
      .trap_taken  (trap_taken)
   );

endmodule

//--- bench/tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen #(
   parameter int RESET_CYCLES = 16
) (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;   // 10 ns period
   end

   initial begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      #1 rst_n = 1'b1;
   end

endmodule

//--- bench/tb_pc_unit.sv
`timescale 1ns/10ps

module tb_pc_unit;

   import pc_pkg::*;

   localparam logic [63:0] RESET_PC = 64'h8000_0000;
   localparam int N_BRANCH = 48;
   localparam int N_JUMP   = 16;
   localparam int N_HAZARD = 6;
   localparam int N_INSTR  = 6 + N_BRANCH + N_JUMP + 2 * N_HAZARD + 16;  // csr writes count 2

   logic        clk;
   logic        rst_n;
   ctrl_t       ctrl;
   logic [63:0] rs1_data;
   logic [63:0] fwd_data;
   logic [63:0] cmp_a;
   logic [63:0] cmp_b;
   csr_wr_t     csr_wr;
   logic        timer_irq;
   logic [63:0] pc;
   logic        jalr_stall;
   logic        trap_taken;

   // reference copies of the architectural state
   logic [63:0] m_pc;
   logic [63:0] m_mtvec;
   logic [63:0] m_mepc;
   logic [63:0] m_imm_q;
   logic        m_mie;
   logic        m_mpie;
   logic        m_hold;

   logic [31:0] rng_state = 32'hea8b2bf4;
   int          cyc = 0;
   int          err_count = 0;
   int          n_checks = 0;
   int          test_errs = 0;
   logic [63:0] exp_q[$];     // expected pc, checked at cycle due_q
   int          due_q[$];
   string       name_q[$];

   tb_clk_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

   pc_unit_top #(.XLEN(64), .RESET_PC(RESET_PC)) UUT (
      .clk(clk), .rst_n(rst_n), .ctrl(ctrl), .rs1_data(rs1_data), .fwd_data(fwd_data),
      .cmp_a(cmp_a), .cmp_b(cmp_b), .csr_wr(csr_wr), .timer_irq(timer_irq),
      .pc(pc), .jalr_stall(jalr_stall), .trap_taken(trap_taken)
   );

   function automatic logic [31:0] xorshift32();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   function automatic logic [63:0] rand64();
      return {xorshift32(), xorshift32()};
   endfunction

   function automatic logic [63:0] word_addr();
      return rand64() & ~64'h3;
   endfunction

   // small signed offset, multiple of 8
   function automatic logic [63:0] rand_imm();
      logic [31:0] r;
      r = xorshift32();
      return {{52{r[11]}}, r[11:3], 3'b000};
   endfunction

   function automatic ctrl_t plain_ctrl();
      ctrl_t c;
      c = '0;
      c.valid = 1'b1;
      return c;
   endfunction

   function automatic logic branch_holds(input cmp_op_e op, input logic [63:0] a,
                                         input logic [63:0] b);
      case (op)
         cmp_beq:  return a == b;
         cmp_bne:  return a != b;
         cmp_blt:  return $signed(a) < $signed(b);
         cmp_bge:  return $signed(a) >= $signed(b);
         cmp_bltu: return a < b;
         default:  return a >= b;   // bgeu
      endcase
   endfunction

   // one step of the redirect priority, updates the model state
   function automatic logic [63:0] next_pc_model(input ctrl_t c, input logic [63:0] rs1,
         input logic [63:0] fwd, input logic [63:0] a, input logic [63:0] b, input logic irq);
      logic [63:0] nxt;
      nxt = m_pc;
      if (m_hold) begin
         nxt    = fwd + m_imm_q;   // ctrl ignored
         m_hold = 1'b0;
      end else if (c.valid) begin
         if (c.branch) begin
            nxt = branch_holds(c.cmp_op, a, b) ? m_pc + c.imm : m_pc + 64'd4;
         end else if (c.jump && !c.jalr) begin
            nxt = m_pc + c.imm;
         end else if (c.jalr && !c.rs1_hazard) begin
            nxt = rs1 + c.imm;
         end else if (c.jalr) begin
            m_hold  = 1'b1;
            m_imm_q = c.imm;
         end else if (c.ebreak) begin
            nxt = RESET_PC;
         end else if (c.ecall) begin
            m_mepc = m_pc;
            m_mpie = m_mie;
            m_mie  = 1'b0;
            nxt    = m_mtvec;
         end else if (c.mret) begin
            nxt    = m_mepc;
            m_mie  = m_mpie;
            m_mpie = 1'b1;
         end else if (irq && m_mie) begin
            m_mepc = m_pc + 64'd4;   // interrupted instruction retires
            m_mpie = m_mie;
            m_mie  = 1'b0;
            nxt    = m_mtvec;
         end else begin
            nxt = m_pc + 64'd4;
         end
      end
      m_pc = nxt;
      return nxt;
   endfunction

   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      n_checks++;
      if (actual !== expected) begin
         err_count++;
         $display("Fail %s: expected %h, actual %h", name, expected, actual);
      end
   endtask

   task automatic issue(input string name, input ctrl_t c, input logic [63:0] rs1,
                        input logic [63:0] fwd, input logic [63:0] a, input logic [63:0] b,
                        input logic irq);
      @(posedge clk);
      #1;
      ctrl      = c;
      rs1_data  = rs1;
      fwd_data  = fwd;
      cmp_a     = a;
      cmp_b     = b;
      timer_irq = irq;
      exp_q.push_back(next_pc_model(c, rs1, fwd, a, b, irq));
      due_q.push_back(cyc + 1);
      name_q.push_back(name);
   endtask

   task automatic csr_write(input csr_sel_e sel, input logic [63:0] data);
      @(posedge clk);
      #1;
      ctrl.valid = 1'b0;
      csr_wr     = '{we: 1'b1, sel: sel, data: data};
      @(posedge clk);
      #1;
      csr_wr.we = 1'b0;
      if (sel == csr_mepc) begin
         m_mepc = data;
      end else begin
         m_mtvec = {data[63:4], 1'b0, data[2:0]};
         m_mie   = m_mie | data[3];   // bit 3 enables interrupts
      end
   endtask

   task automatic end_test(input string name);
      @(posedge clk);
      #1;
      ctrl.valid = 1'b0;   // last instruction taken, decode goes idle
      while (exp_q.size() != 0) begin
         @(negedge clk);
      end
      if (err_count == test_errs) begin
         $display("test %-8s done, no errors", name);
      end else begin
         $display("test %-8s done, %0d errors", name, err_count - test_errs);
      end
      test_errs = err_count;
   endtask

   always @(posedge clk) cyc <= cyc + 1;

   // pc is stable at the falling edge
   always @(negedge clk) begin
      if (due_q.size() != 0 && due_q[0] == cyc) begin
         check_value(name_q.pop_front(), exp_q.pop_front(), pc);
         void'(due_q.pop_front());
      end
   end

   initial begin
      repeat (16 + N_INSTR * 20) @(posedge clk);
      $display("timeout: tests did not finish within %0d cycles", 16 + N_INSTR * 20);
      $display("Simulation failed");
      $finish;
   end

   initial begin
      ctrl_t       c;
      cmp_op_e     ops[6];
      logic [63:0] a;
      ctrl      = '0;
      rs1_data  = '0;
      fwd_data  = '0;
      cmp_a     = '0;
      cmp_b     = '0;
      csr_wr    = '0;
      timer_irq = 1'b0;
      m_pc      = RESET_PC;
      m_mtvec   = '0;
      m_mepc    = '0;
      m_imm_q   = '0;
      m_mie     = 1'b0;
      m_mpie    = 1'b0;
      m_hold    = 1'b0;
      ops       = '{cmp_beq, cmp_bne, cmp_blt, cmp_bge, cmp_bltu, cmp_bgeu};
      wait (rst_n === 1'b1);
      @(negedge clk);
      check_value("reset", RESET_PC, pc);
      check_value("reset", 64'd0, {63'd0, jalr_stall});
      check_value("reset", 64'd0, {63'd0, trap_taken});
      c = plain_ctrl();
      repeat (4) issue("plain", c, '0, '0, '0, '0, 1'b0);
      c.valid = 1'b0;
      repeat (2) issue("plain", c, '0, '0, '0, '0, 1'b0);   // pc holds
      end_test("plain");

      for (int i = 0; i < N_BRANCH; i++) begin
         c        = plain_ctrl();
         c.branch = 1'b1;
         c.cmp_op = ops[i % 6];
         c.imm    = rand_imm();
         a        = rand64();
         issue("branch", c, '0, '0, a, (xorshift32() % 4 == 0) ? a : rand64(), 1'b0);
      end
      end_test("branch");

      for (int i = 0; i < N_JUMP; i++) begin
         c      = plain_ctrl();
         c.jump = 1'b1;
         c.jalr = (i % 2 == 1);   // alternate jal and jalr
         c.imm  = rand_imm();
         issue("jump", c, word_addr(), '0, '0, '0, 1'b0);
      end
      end_test("jump");

      for (int i = 0; i < N_HAZARD; i++) begin
         c            = plain_ctrl();
         c.jump       = 1'b1;
         c.jalr       = 1'b1;
         c.rs1_hazard = 1'b1;
         c.imm        = rand_imm();
         issue("hazard", c, word_addr(), '0, '0, '0, 1'b0);   // stale rs1
         @(negedge clk);
         check_value("hazard", 64'd1, {63'd0, jalr_stall});
         c.valid = 1'b0;
         c.imm   = rand_imm();   // must not replace the latched imm
         issue("hazard", c, '0, word_addr(), '0, '0, 1'b0);
         @(negedge clk);
         check_value("hazard", 64'd0, {63'd0, jalr_stall});
      end
      end_test("hazard");

      csr_write(csr_mtvec, 64'h0000_0000_8000_1000);
      c       = plain_ctrl();
      c.ecall = 1'b1;
      issue("traps", c, '0, '0, '0, '0, 1'b0);
      c       = plain_ctrl();
      c.mret  = 1'b1;
      issue("traps", c, '0, '0, '0, '0, 1'b0);   // back to the ecall
      @(negedge clk);
      check_value("traps", 64'd1, {63'd0, trap_taken});
      c        = plain_ctrl();
      c.ebreak = 1'b1;
      issue("traps", c, '0, '0, '0, '0, 1'b0);
      end_test("traps");

      c = plain_ctrl();
      repeat (2) issue("irq", c, '0, '0, '0, '0, 1'b1);   // mie still clear
      csr_write(csr_mtvec, 64'h0000_0000_8000_2008);
      issue("irq", c, '0, '0, '0, '0, 1'b1);
      issue("irq", c, '0, '0, '0, '0, 1'b1);   // masked until mret
      @(negedge clk);
      check_value("irq", 64'd1, {63'd0, trap_taken});
      c.mret = 1'b1;
      issue("irq", c, '0, '0, '0, '0, 1'b1);
      c = plain_ctrl();
      issue("irq", c, '0, '0, '0, '0, 1'b0);
      end_test("irq");

      $display("checks %0d, errors %0d", n_checks, err_count);
      if (err_count == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

//--- src.f
hdl/pc_pkg.sv
hdl/branch_cmp.sv
hdl/pc_sequencer.sv
hdl/trap_csr.sv
hdl/pc_unit_top.sv
bench/tb_clk_gen.sv
bench/tb_pc_unit.sv

//--- run_sim.sh
#!/bin/bash
# build and run the pc unit testbench with Verilator

verilator --binary --timing --assert -f src.f --top-module tb_pc_unit -o sim_pc_unit
if [ $? -ne 0 ]; then
   echo "verilator build returned an error"
   exit 1
fi

./obj_dir/sim_pc_unit > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulator exited with status $status"
   exit 1
fi

if grep -q "^Simulation passed$" sim.log; then
   exit 0
fi
exit 1
